// File: verilog/fetch_pkg.sv
// Shared widths, types and instruction constants for the RV32 fetch unit, imported by each module
`default_nettype none

package fetch_pkg;

  //////////////////////////////////////////////////
  // Widths

  localparam int unsigned XLEN             = 32;
  localparam int unsigned PARCEL_W         = 16;
  localparam int unsigned PARCELS_PER_WORD = XLEN / PARCEL_W;

  typedef logic [XLEN-1:0]     addr_t;
  typedef logic [PARCEL_W-1:0] parcel_t;
  typedef logic [31:0]         insn_t;

  //////////////////////////////////////////////////
  // Compressed parcel views

  // CI format, immediate and register forms
  typedef struct packed {
    logic [2:0] funct3;
    logic       b12;     // imm[5] or funct bit
    logic [4:0] rd;
    logic [4:0] imm;     // imm[4:0]
    logic [1:0] op;      // Quadrant
  } rvc_ci_t;

  // CR format, register-register and jumps
  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_cr_t;

  typedef union packed {
    rvc_ci_t ci;
    rvc_cr_t cr;
  } rvc_parcel_u;

  //////////////////////////////////////////////////
  // Instruction words and opcodes

  localparam insn_t NOP_INSN     = 32'h0000_0013;   // addi x0,x0,0
  localparam insn_t ILLEGAL_INSN = 32'h0000_0000;
  localparam insn_t WFI_INSN     = 32'h1050_0073;

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

// File: verilog/fetch_addr_gen.sv
// Linear instruction-memory address generator with request throttling and flush on redirect
`timescale 1ns/1ps
`default_nettype none

module fetch_addr_gen #(
  parameter fetch_pkg::addr_t PC_INIT = 32'h200
) (
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire              redirect_i,
  input  fetch_pkg::addr_t redirect_pc_i,
  input  wire              queue_almost_full_i,
  input  wire              imem_ack_i,
  output logic             imem_req_o,
  output fetch_pkg::addr_t imem_adr_o,
  output logic             imem_flush_o
);
  import fetch_pkg::*;

  localparam addr_t WORD_BYTES = addr_t'(XLEN / 8);

  assign imem_req_o   = ~(queue_almost_full_i | redirect_i);
  assign imem_flush_o = redirect_i;   // Drops anything still in flight

  // A redirect may land on a half word, later steps go to the next aligned word
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      imem_adr_o <= PC_INIT;
    else if (redirect_i)
      imem_adr_o <= redirect_pc_i;
    else if (imem_req_o && imem_ack_i)
      imem_adr_o <= (imem_adr_o + WORD_BYTES) & ~(WORD_BYTES - addr_t'(1));
  end

endmodule

`default_nettype wire

// File: verilog/parcel_queue.sv
// Shift queue of instruction parcels; two-parcel writes, up to two-parcel reads from the head
`timescale 1ns/1ps
`default_nettype none

module parcel_queue #(
  parameter  int unsigned QUEUE_DEPTH = 12,
  localparam int unsigned LEVEL_W     = $clog2(QUEUE_DEPTH + 1)
) (
  input  wire                                                  clk_i,
  input  wire                                                  rst_ni,
  input  wire                                                  flush_i,
  input  fetch_pkg::parcel_t [fetch_pkg::PARCELS_PER_WORD-1:0] parcel_i,
  input  wire [fetch_pkg::PARCELS_PER_WORD-1:0]                parcel_valid_i,
  input  wire                                                  error_i,
  input  wire [1:0]                                            rd_cnt_i,
  output fetch_pkg::parcel_t [1:0]                             head_o,
  output logic [1:0]                                           head_error_o,
  output logic [LEVEL_W-1:0]                                   level_o,
  output logic                                                 almost_full_o
);
  import fetch_pkg::*;

  // Room kept for words already requested from memory
  localparam int unsigned AF_LEVEL = QUEUE_DEPTH - 3 * PARCELS_PER_WORD;

  parcel_t [QUEUE_DEPTH-1:0] q_r, q_nxt;
  logic    [QUEUE_DEPTH-1:0] err_r, err_nxt;
  logic    [LEVEL_W-1:0]     level_rd;   // Level after the read
  logic    [LEVEL_W-1:0]     level_nxt;

  //////////////////////////////////////////////////
  // Read shift, then append at the new tail

  always_comb
  begin
    level_rd  = level_o - LEVEL_W'(rd_cnt_i);
    level_nxt = level_rd + LEVEL_W'(parcel_valid_i[0]) + LEVEL_W'(parcel_valid_i[1]);
    for (int i = 0; i < QUEUE_DEPTH; i++)
    begin
      q_nxt[i]   = q_r[i];
      err_nxt[i] = err_r[i];
      if (i + int'(rd_cnt_i) < QUEUE_DEPTH)
      begin
        q_nxt[i]   = q_r[i + int'(rd_cnt_i)];
        err_nxt[i] = err_r[i + int'(rd_cnt_i)];
      end
      if (parcel_valid_i[0] && i == int'(level_rd))
      begin
        q_nxt[i]   = parcel_i[0];
        err_nxt[i] = error_i;
      end
      // Upper parcel follows the lower one, or goes first when alone
      if (parcel_valid_i[1] && i == int'(level_rd) + int'(parcel_valid_i[0]))
      begin
        q_nxt[i]   = parcel_i[1];
        err_nxt[i] = error_i;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    q_r   <= q_nxt;
    err_r <= err_nxt;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      level_o <= '0;
    else if (flush_i)
      level_o <= '0;   // In-flight data this cycle is dropped too
    else
      level_o <= level_nxt;
  end

  assign head_o        = q_r[1:0];
  assign head_error_o  = err_r[1:0];
  assign almost_full_o = (level_o >= LEVEL_W'(AF_LEVEL));

endmodule

`default_nettype wire

// File: verilog/rvc_expander.sv
// Combinational RVC to RV32 expansion for the supported compressed subset; others give illegal
`timescale 1ns/1ps
`default_nettype none

module rvc_expander (
  input  fetch_pkg::rvc_parcel_u parcel_i,
  output fetch_pkg::insn_t       insn_o
);
  import fetch_pkg::*;

  logic [11:0] imm_ci;   // Sign-extended CI immediate
  logic [20:0] off_cj;   // C.J byte offset
  logic [15:0] raw;

  assign raw    = parcel_i;
  assign imm_ci = {{6{parcel_i.ci.b12}}, parcel_i.ci.b12, parcel_i.ci.imm};
  assign off_cj = {{10{raw[12]}}, raw[8], raw[10:9], raw[6], raw[7], raw[2], raw[11],
                   raw[5:3], 1'b0};

  always_comb
  begin
    insn_o = ILLEGAL_INSN;
    case (parcel_i.ci.op)
      2'b01:
      begin
        case (parcel_i.ci.funct3)
          3'b000:   // C.ADDI, C.NOP when rd and imm are zero
            insn_o = {imm_ci, parcel_i.ci.rd, 3'b000, parcel_i.ci.rd, OPC_OP_IMM};
          3'b010:   // C.LI
            insn_o = {imm_ci, 5'd0, 3'b000, parcel_i.ci.rd, OPC_OP_IMM};
          3'b101:   // C.J
            insn_o = {off_cj[20], off_cj[10:1], off_cj[11], off_cj[19:12], 5'd0, OPC_JAL};
          default:
            insn_o = ILLEGAL_INSN;
        endcase
      end
      2'b10:
      begin
        if (parcel_i.cr.funct4 == 4'b1000)
        begin
          if (parcel_i.cr.rs2 != 5'd0)
            insn_o = {7'd0, parcel_i.cr.rs2, 5'd0, 3'b000, parcel_i.cr.rd, OPC_OP};  // C.MV
          else if (parcel_i.cr.rd != 5'd0)
            insn_o = {12'd0, parcel_i.cr.rd, 3'b000, 5'd0, OPC_JALR};             // C.JR
        end
        else if (parcel_i.cr.funct4 == 4'b1001 && parcel_i.cr.rs2 != 5'd0)
        begin
          // C.ADD
          insn_o = {7'd0, parcel_i.cr.rs2, parcel_i.cr.rd, 3'b000, parcel_i.cr.rd, OPC_OP};
        end
      end
      default:
        insn_o = ILLEGAL_INSN;   // Quadrant 0 is not supported
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/fetch_issue_stage.sv
// Issue stage; measures the head instruction, pops the queue, tracks the PC, registers outputs
`timescale 1ns/1ps
`default_nettype none

module fetch_issue_stage #(
  parameter fetch_pkg::addr_t PC_INIT = 32'h200,
  parameter int unsigned      LEVEL_W = 4
) (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  input  wire                      redirect_i,
  input  fetch_pkg::addr_t         redirect_pc_i,
  input  wire                      stall_i,
  input  fetch_pkg::parcel_t [1:0] head_i,
  input  wire [1:0]                head_error_i,
  input  wire [LEVEL_W-1:0]        level_i,
  input  fetch_pkg::insn_t         rvc_insn_i,
  output logic [1:0]               rd_cnt_o,
  output fetch_pkg::addr_t         if_pc_o,
  output fetch_pkg::insn_t         if_insn_o,
  output logic                     if_bubble_o,
  output logic                     if_fault_o
);
  import fetch_pkg::*;

  logic  is_32;
  logic  have_one;
  logic  have_two;
  logic  issue;
  addr_t pc;          // PC of the head instruction
  insn_t word32;
  insn_t insn_nxt;
  logic  fault_nxt;

  //////////////////////////////////////////////////
  // Length decode and issue

  assign is_32    = &head_i[0][1:0];
  assign have_one = (level_i != '0);
  assign have_two = (level_i > LEVEL_W'(1));
  assign issue    = ~stall_i & ~redirect_i & have_one & (~is_32 | have_two);
  assign rd_cnt_o = issue ? (is_32 ? 2'd2 : 2'd1) : 2'd0;

  assign word32    = {head_i[1], head_i[0]};
  assign insn_nxt  = is_32 ? ((word32 == WFI_INSN) ? NOP_INSN : word32) : rvc_insn_i;
  assign fault_nxt = head_error_i[0] | (is_32 & head_error_i[1]);

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pc <= PC_INIT;
    else if (redirect_i)
      pc <= redirect_pc_i;
    else if (issue)
      pc <= pc + (is_32 ? addr_t'(4) : addr_t'(2));
  end

  //////////////////////////////////////////////////
  // Output registers

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      if_pc_o    <= PC_INIT;
      if_insn_o  <= NOP_INSN;
      if_fault_o <= 1'b0;
    end
    else if (issue)
    begin
      if_pc_o    <= pc;
      if_insn_o  <= insn_nxt;
      if_fault_o <= fault_nxt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      if_bubble_o <= 1'b1;
    else if (redirect_i)
      if_bubble_o <= 1'b1;     // Stale instruction is dropped
    else if (!stall_i)
      if_bubble_o <= ~issue;
  end

endmodule

`default_nettype wire

// File: verilog/riscv_fetch.sv
// RV32 instruction fetch top level; connects the memory port, parcel queue and issue stage
`timescale 1ns/1ps
`default_nettype none

module riscv_fetch #(
  parameter fetch_pkg::addr_t PC_INIT     = 32'h200,
  parameter int unsigned      QUEUE_DEPTH = 12
) (
  input  wire                                                   clk_i,
  input  wire                                                   rst_ni,
  // Instruction memory
  output logic                                                  imem_req_o,
  output fetch_pkg::addr_t                                      imem_adr_o,
  input  wire                                                   imem_ack_i,
  output logic                                                  imem_flush_o,
  input  fetch_pkg::parcel_t [fetch_pkg::PARCELS_PER_WORD-1:0]  imem_parcel_i,
  input  wire [fetch_pkg::PARCELS_PER_WORD-1:0]                 imem_parcel_valid_i,
  input  wire                                                   imem_error_i,
  // Redirect and decode
  input  wire                                                   redirect_i,
  input  fetch_pkg::addr_t                                      redirect_pc_i,
  input  wire                                                   stall_i,
  output fetch_pkg::addr_t                                      if_pc_o,
  output fetch_pkg::insn_t                                      if_insn_o,
  output logic                                                  if_bubble_o,
  output logic                                                  if_fault_o
);
  import fetch_pkg::*;

  localparam int unsigned LEVEL_W = $clog2(QUEUE_DEPTH + 1);

  parcel_t [1:0]      head;         // Two oldest parcels
  logic    [1:0]      head_error;
  logic [LEVEL_W-1:0] level;
  logic               almost_full;
  logic    [1:0]      rd_cnt;
  insn_t              rvc_insn;

  fetch_addr_gen #(
    .PC_INIT (PC_INIT)
  ) u_addr_gen (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .redirect_i          (redirect_i),
    .redirect_pc_i       (redirect_pc_i),
    .queue_almost_full_i (almost_full),
    .imem_ack_i          (imem_ack_i),
    .imem_req_o          (imem_req_o),
    .imem_adr_o          (imem_adr_o),
    .imem_flush_o        (imem_flush_o)
  );

  parcel_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (imem_flush_o),
    .parcel_i       (imem_parcel_i),
    .parcel_valid_i (imem_parcel_valid_i),
    .error_i        (imem_error_i),
    .rd_cnt_i       (rd_cnt),
    .head_o         (head),
    .head_error_o   (head_error),
    .level_o        (level),
    .almost_full_o  (almost_full)
  );

  rvc_expander u_rvc (
    .parcel_i (head[0]),
    .insn_o   (rvc_insn)
  );

  fetch_issue_stage #(
    .PC_INIT (PC_INIT),
    .LEVEL_W (LEVEL_W)
  ) u_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .stall_i       (stall_i),
    .head_i        (head),
    .head_error_i  (head_error),
    .level_i       (level),
    .rvc_insn_i    (rvc_insn),
    .rd_cnt_o      (rd_cnt),
    .if_pc_o       (if_pc_o),
    .if_insn_o     (if_insn_o),
    .if_bubble_o   (if_bubble_o),
    .if_fault_o    (if_fault_o)
  );

endmodule

`default_nettype wire

// File: testbench/fetch_sva.sv
// Concurrent checks on the fetch unit ports, bound into riscv_fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_sva (
  input wire              clk_i,
  input wire              rst_ni,
  input wire              imem_req_o,
  input wire              imem_flush_o,
  input wire              redirect_i,
  input wire              stall_i,
  input fetch_pkg::addr_t if_pc_o,
  input fetch_pkg::insn_t if_insn_o,
  input wire              if_bubble_o,
  input wire              if_fault_o
);

  // No new request while in-flight words are dropped
  assert property (@(posedge clk_i) disable iff (!rst_ni) imem_flush_o |-> !imem_req_o)
    else $error("imem_req_o high during imem_flush_o");

  assert property (@(posedge clk_i) disable iff (!rst_ni) redirect_i |=> if_bubble_o)
    else $error("if_bubble_o not set after redirect_i");

  // A stalled edge leaves all outputs untouched
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (stall_i && !redirect_i) |=> ($stable(if_pc_o) && $stable(if_insn_o) &&
                                                 $stable(if_bubble_o) && $stable(if_fault_o)))
    else $error("Outputs changed across a stalled cycle");

endmodule

bind riscv_fetch fetch_sva u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .imem_req_o   (imem_req_o),
  .imem_flush_o (imem_flush_o),
  .redirect_i   (redirect_i),
  .stall_i      (stall_i),
  .if_pc_o      (if_pc_o),
  .if_insn_o    (if_insn_o),
  .if_bubble_o  (if_bubble_o),
  .if_fault_o   (if_fault_o)
);

`default_nettype wire

// File: testbench/tb_riscv_fetch.sv
// Directed testbench for the RV32 fetch unit; models instruction memory and checks the issue stream
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_fetch;
  import fetch_pkg::*;

  localparam int    CLK_PERIOD  = 8;
  localparam addr_t PC_INIT     = 32'h200;
  localparam int    TEST_CYCLES = 10 + 60 + 60 + 80 + 50 + 50;   // Reset first, then each test
  localparam int    WATCHDOG_NS = TEST_CYCLES * 4 * CLK_PERIOD;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            imem_req_o;
  addr_t                           imem_adr_o;
  logic                            imem_ack_i;
  logic                            imem_flush_o;
  parcel_t [PARCELS_PER_WORD-1:0]  imem_parcel_i;
  logic    [PARCELS_PER_WORD-1:0]  imem_parcel_valid_i;
  logic                            imem_error_i;
  logic                            redirect_i;
  addr_t                           redirect_pc_i;
  logic                            stall_i;
  addr_t                           if_pc_o;
  insn_t                           if_insn_o;
  logic                            if_bubble_o;
  logic                            if_fault_o;

  logic [31:0] mem [0:1023];
  addr_t       fault_tab[$];
  addr_t       exp_pc[$];
  insn_t       exp_insn[$];
  bit          exp_fault[$];
  addr_t       obs_pc[$];
  insn_t       obs_insn[$];
  bit          obs_fault[$];
  addr_t       build_pc;      // Next free program address
  logic [31:0] rng_state;
  bit          take;
  addr_t       take_adr;
  bit          fresh;

  riscv_fetch #(
    .PC_INIT     (PC_INIT),
    .QUEUE_DEPTH (12)
  ) u_dut (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .imem_req_o          (imem_req_o),
    .imem_adr_o          (imem_adr_o),
    .imem_ack_i          (imem_ack_i),
    .imem_flush_o        (imem_flush_o),
    .imem_parcel_i       (imem_parcel_i),
    .imem_parcel_valid_i (imem_parcel_valid_i),
    .imem_error_i        (imem_error_i),
    .redirect_i          (redirect_i),
    .redirect_pc_i       (redirect_pc_i),
    .stall_i             (stall_i),
    .if_pc_o             (if_pc_o),
    .if_insn_o           (if_insn_o),
    .if_bubble_o         (if_bubble_o),
    .if_fault_o          (if_fault_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Memory model and issue monitor

  // Word accepted at one edge is returned through the next cycle
  always @(posedge clk_i)
  begin
    take     = rst_ni && imem_req_o && imem_ack_i && !imem_flush_o;
    take_adr = imem_adr_o;
    #1;
    imem_parcel_i[0]    = mem[take_adr[11:2]][15:0];
    imem_parcel_i[1]    = mem[take_adr[11:2]][31:16];
    imem_parcel_valid_i = take ? (take_adr[1] ? 2'b10 : 2'b11) : 2'b00;
    imem_error_i        = take && in_fault(take_adr);
  end

  // A new instruction shows up only after an unstalled edge
  always
  begin
    @(posedge clk_i);
    fresh = rst_ni && !stall_i;
    @(negedge clk_i);
    if (fresh && !if_bubble_o)
    begin
      obs_pc.push_back(if_pc_o);
      obs_insn.push_back(if_insn_o);
      obs_fault.push_back(if_fault_o);
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    stop_run("Watchdog timeout, the tests did not finish in time");
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic stop_run(string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_insn(string name, insn_t got, insn_t exp);
    if (got !== exp)
      stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_pc(string name, addr_t got, addr_t exp);
    if (got !== exp)
      stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(string name, bit got, bit exp);
    if (got !== exp)
      stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
  endtask

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic bit in_fault(addr_t a);
    bit hit;
    hit = 1'b0;
    foreach (fault_tab[i])
      if (fault_tab[i][31:2] == a[31:2])
        hit = 1'b1;
    return hit;
  endfunction

  function automatic rvc_parcel_u mk_ci(logic [2:0] f3, logic b12, logic [4:0] rd,
                                        logic [4:0] imm, logic [1:0] op);
    rvc_parcel_u p;
    p.ci.funct3 = f3;
    p.ci.b12    = b12;
    p.ci.rd     = rd;
    p.ci.imm    = imm;
    p.ci.op     = op;
    return p;
  endfunction

  function automatic rvc_parcel_u mk_cr(logic [3:0] f4, logic [4:0] rd, logic [4:0] rs2,
                                        logic [1:0] op);
    rvc_parcel_u p;
    p.cr.funct4 = f4;
    p.cr.rd     = rd;
    p.cr.rs2    = rs2;
    p.cr.op     = op;
    return p;
  endfunction

  // Reference expansion, built from the RV32 I, R and J encodings
  function automatic insn_t ref_expand(rvc_parcel_u p);
    logic [15:0] w;
    logic [11:0] imm;
    logic [20:0] off;
    insn_t       res;
    w   = p;
    imm = {{7{w[12]}}, w[6:2]};
    off = {{9{w[12]}}, w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0};
    res = ILLEGAL_INSN;
    if (p.ci.op == 2'b01 && p.ci.funct3 == 3'b000)
      res = {imm, p.ci.rd, 3'b000, p.ci.rd, OPC_OP_IMM};
    else if (p.ci.op == 2'b01 && p.ci.funct3 == 3'b010)
      res = {imm, 5'd0, 3'b000, p.ci.rd, OPC_OP_IMM};
    else if (p.ci.op == 2'b01 && p.ci.funct3 == 3'b101)
      res = {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
    else if (p.cr.op == 2'b10 && p.cr.funct4 == 4'b1000 && p.cr.rs2 != 5'd0)
      res = {7'd0, p.cr.rs2, 5'd0, 3'b000, p.cr.rd, OPC_OP};
    else if (p.cr.op == 2'b10 && p.cr.funct4 == 4'b1000 && p.cr.rd != 5'd0)
      res = {12'd0, p.cr.rd, 3'b000, 5'd0, OPC_JALR};
    else if (p.cr.op == 2'b10 && p.cr.funct4 == 4'b1001 && p.cr.rs2 != 5'd0)
      res = {7'd0, p.cr.rs2, p.cr.rd, 3'b000, p.cr.rd, OPC_OP};
    return res;
  endfunction

  function automatic void put_parcel(addr_t a, parcel_t v);
    if (a[1])
      mem[a[11:2]][31:16] = v;
    else
      mem[a[11:2]][15:0] = v;
  endfunction

  function automatic void emit16(rvc_parcel_u p);
    put_parcel(build_pc, p);
    exp_pc.push_back(build_pc);
    exp_insn.push_back(ref_expand(p));
    exp_fault.push_back(in_fault(build_pc));
    build_pc = build_pc + 2;
  endfunction

  function automatic void emit32(insn_t w);
    put_parcel(build_pc, w[15:0]);
    put_parcel(build_pc + 2, w[31:16]);
    exp_pc.push_back(build_pc);
    exp_insn.push_back((w == WFI_INSN) ? NOP_INSN : w);
    exp_fault.push_back(in_fault(build_pc) || in_fault(build_pc + 2));
    build_pc = build_pc + 4;
  endfunction

  function automatic insn_t random_op_imm();
    logic [31:0] r;
    r = next_random();
    return {r[31:7], OPC_OP_IMM};
  endfunction

  task automatic redirect_to(addr_t pc);
    @(posedge clk_i);
    #1;
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    #1;
    check_flag("imem_flush_o", imem_flush_o, 1'b1);
    check_flag("imem_req_o", imem_req_o, 1'b0);
    @(posedge clk_i);
    #1;
    redirect_i = 1'b0;
    obs_pc.delete();     // Issues from before the redirect
    obs_insn.delete();
    obs_fault.delete();
    check_flag("if_bubble_o", if_bubble_o, 1'b1);
    check_pc("imem_adr_o", imem_adr_o, pc);
  endtask

  task automatic check_stream(int n);
    for (int i = 0; i < n; i++)
    begin
      while (obs_pc.size() == 0)
        @(posedge clk_i);
      check_pc("if_pc_o", obs_pc.pop_front(), exp_pc.pop_front());
      check_insn("if_insn_o", obs_insn.pop_front(), exp_insn.pop_front());
      check_flag("if_fault_o", obs_fault.pop_front(), exp_fault.pop_front());
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset();
    check_flag("if_bubble_o", if_bubble_o, 1'b1);
    check_flag("imem_req_o", imem_req_o, 1'b1);
    check_flag("imem_flush_o", imem_flush_o, 1'b0);
    check_flag("if_fault_o", if_fault_o, 1'b0);
    check_pc("if_pc_o", if_pc_o, PC_INIT);
    check_insn("if_insn_o", if_insn_o, NOP_INSN);
  endtask

  task automatic test_random32();
    build_pc = 32'h300;
    for (int i = 0; i < 12; i++)
      emit32((i == 5) ? WFI_INSN : random_op_imm());
    redirect_to(32'h300);
    check_stream(exp_pc.size());
  endtask

  task automatic test_compressed();
    build_pc = 32'h400;
    emit16(mk_ci(3'b000, 1'b1, 5'd5, 5'b11101, 2'b01));    // C.ADDI x5,-3
    emit16(mk_ci(3'b010, 1'b0, 5'd10, 5'd7, 2'b01));       // C.LI x10,7
    emit16(mk_ci(3'b000, 1'b0, 5'd0, 5'd0, 2'b01));        // C.NOP
    emit32(random_op_imm());                               // Straddles two words
    emit16(mk_cr(4'b1000, 5'd8, 5'd9, 2'b10));             // C.MV
    emit16(mk_cr(4'b1001, 5'd8, 5'd3, 2'b10));             // C.ADD
    emit16(mk_ci(3'b101, 1'b1, 5'b10110, 5'b01011, 2'b01)); // C.J backwards
    emit16(mk_cr(4'b1000, 5'd1, 5'd0, 2'b10));             // C.JR x1
    emit16(mk_cr(4'b1000, 5'd0, 5'd0, 2'b10));             // Reserved C.JR x0
    emit16(mk_ci(3'b000, 1'b0, 5'd9, 5'd4, 2'b00));        // Quadrant 0
    emit16(mk_ci(3'b011, 1'b0, 5'd3, 5'd1, 2'b01));        // C.LUI
    emit16(mk_cr(4'b1001, 5'd0, 5'd0, 2'b10));             // C.EBREAK
    emit32(random_op_imm());
    redirect_to(32'h400);
    check_stream(exp_pc.size());
  endtask

  task automatic test_stall();
    addr_t hold_pc;
    insn_t hold_insn;
    bit    hold_bubble;
    bit    hold_fault;
    bit    req_dropped;
    build_pc    = 32'h500;
    req_dropped = 1'b0;
    for (int i = 0; i < 12; i++)
    begin
      if (i % 2 == 0)
        emit32(random_op_imm());
      else
        emit16(mk_ci(3'b010, 1'b0, 5'(i), 5'(i + 3), 2'b01));
    end
    redirect_to(32'h500);
    check_stream(3);
    @(posedge clk_i);
    #1;
    stall_i = 1'b1;
    @(negedge clk_i);
    hold_pc     = if_pc_o;
    hold_insn   = if_insn_o;
    hold_bubble = if_bubble_o;
    hold_fault  = if_fault_o;
    repeat (20)
    begin
      @(negedge clk_i);
      check_pc("if_pc_o", if_pc_o, hold_pc);
      check_insn("if_insn_o", if_insn_o, hold_insn);
      check_flag("if_bubble_o", if_bubble_o, hold_bubble);
      check_flag("if_fault_o", if_fault_o, hold_fault);
      if (!imem_req_o)
        req_dropped = 1'b1;
    end
    if (!req_dropped)
      stop_run("imem_req_o stayed high while the queue filled during the stall");
    @(posedge clk_i);
    #1;
    stall_i = 1'b0;
    check_stream(exp_pc.size());
  endtask

  task automatic test_misaligned_redirect();
    build_pc = 32'h602;
    emit16(mk_ci(3'b010, 1'b1, 5'd12, 5'd30, 2'b01));
    emit32(random_op_imm());
    emit16(mk_cr(4'b1000, 5'd4, 5'd6, 2'b10));
    emit32(random_op_imm());
    emit32(WFI_INSN);
    emit16(mk_cr(4'b1001, 5'd7, 5'd7, 2'b10));
    repeat (5) @(posedge clk_i);    // Let the old stream run
    redirect_to(32'h602);
    check_stream(exp_pc.size());
  endtask

  task automatic test_fault();
    fault_tab.push_back(32'h708);
    build_pc = 32'h700;
    for (int i = 0; i < 5; i++)
      emit32(random_op_imm());
    emit16(mk_ci(3'b000, 1'b0, 5'd0, 5'd0, 2'b01));
    redirect_to(32'h700);
    check_stream(exp_pc.size());
  endtask

  initial
  begin
    clk_i               = 1'b0;
    rst_ni              = 1'b0;
    imem_ack_i          = 1'b1;
    imem_parcel_i       = '0;
    imem_parcel_valid_i = '0;
    imem_error_i        = 1'b0;
    redirect_i          = 1'b0;
    redirect_pc_i       = '0;
    stall_i             = 1'b0;
    rng_state           = 32'h29059b6b;
    // Fill with addi x1,x0,index so every word differs
    for (int i = 0; i < 1024; i++)
      mem[i] = {2'b00, 10'(i), 5'd0, 3'b000, 5'd1, OPC_OP_IMM};
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset();
    test_random32();
    test_compressed();
    test_stall();
    test_misaligned_redirect();
    test_fault();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
verilog/fetch_pkg.sv
verilog/fetch_addr_gen.sv
verilog/parcel_queue.sv
verilog/rvc_expander.sv
verilog/fetch_issue_stage.sv
verilog/riscv_fetch.sv
testbench/fetch_sva.sv
testbench/tb_riscv_fetch.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_riscv_fetch -f filelist.f -Mdir obj_dir -o sim_fetch

./obj_dir/sim_fetch | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "Fail message found in sim.log"
  exit 1
fi
grep -q "Simulation PASSED" sim.log
